/* include/mod_mult_cfg.svh */
// Build settings for the modular multiplier, pulled in by mod_mult_pkg and the testbench
`ifndef MOD_MULT_CFG_SVH
`define MOD_MULT_CFG_SVH

// Radix of one coefficient, each word weighs 2^8 more than the one below
`define MOD_MULT_WORD_BITS 8

// Words in a fully reduced value
`define MOD_MULT_NUM_WORDS 4

// Headroom bits on top of each word
`define MOD_MULT_REDUN_BITS 1

// Address width of one reduction table
`define MOD_MULT_RED_BITS 9

// Odd modulus, must stay below 2^(WORD_BITS*NUM_WORDS)
// Largest 32-bit prime
`define MOD_MULT_MODULUS 32'd4294967291

`endif

/* logic/mod_mult_pkg.sv */
// Shared types and derived widths for the modular multiplier RTL and its testbench
`include "mod_mult_cfg.svh"

package mod_mult_pkg;

  localparam int WORD_BITS  = `MOD_MULT_WORD_BITS;
  localparam int NUM_WORDS  = `MOD_MULT_NUM_WORDS;
  localparam int REDUN_BITS = `MOD_MULT_REDUN_BITS;
  localparam int RED_BITS   = `MOD_MULT_RED_BITS;

  localparam int I_WORD    = NUM_WORDS + 1;          // Extra top word for chained use
  localparam int COEF_BITS = WORD_BITS + REDUN_BITS; // One DSP operand
  localparam int RES_BITS  = NUM_WORDS * WORD_BITS;

  typedef logic [COEF_BITS-1:0] coef_t;
  typedef coef_t [I_WORD-1:0]   poly_t;    // Redundant operand and result
  typedef logic [RES_BITS-1:0]  residue_t; // Plain binary residue

  localparam residue_t MODULUS = `MOD_MULT_MODULUS;

  localparam int MULT_SPLITS = (2*COEF_BITS + WORD_BITS - 1) / WORD_BITS; // Word slices per product
  localparam int ACCUM_COLS  = 2*(I_WORD-1) + MULT_SPLITS;  // Columns the grid spreads over
  localparam int RED_STAGES  = (COEF_BITS + RED_BITS - 1) / RED_BITS; // Table slices per column
  localparam int UPPER_COLS  = ACCUM_COLS - NUM_WORDS;      // Columns folded through tables

  // Register stages
  localparam int CORE_STAGES     = 7;
  localparam int RED_ONLY_STAGES = 3; // Reduce-only enters at the address registers
  localparam int CONV_STAGES     = 2;

  localparam int LATENCY_MUL = CORE_STAGES + CONV_STAGES;
  localparam int LATENCY_RED = RED_ONLY_STAGES + CONV_STAGES;

endpackage

/* logic/mod_mult_unit.sv */
// Top level modular multiplier: core pipeline followed by the binary converter
`timescale 1ns/1ns

module mod_mult_unit
  import mod_mult_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_val,          // Request pulse, one per cycle at most
  input  logic     i_reduce_only,  // Reduce A, ignore B
  input  poly_t    i_dat_a_i,
  input  poly_t    i_dat_b_i,
  output logic     o_val,          // LATENCY_MUL or LATENCY_RED after i_val
  output residue_t o_dat_o,        // Binary residue
  output poly_t    o_dat_red_o     // Same value in redundant form
);

  poly_t core_dat;
  logic  core_val;

  poly_mod_mult u_core (
    .i_clk         ( i_clk         ),
    .i_rst         ( i_rst         ),
    .i_val         ( i_val         ),
    .i_reduce_only ( i_reduce_only ),
    .i_dat_a_i     ( i_dat_a_i     ),
    .i_dat_b_i     ( i_dat_b_i     ),
    .o_dat_o       ( core_dat      ),
    .o_val         ( core_val      )
  );

  redundant_to_binary u_conv (
    .i_clk       ( i_clk       ),
    .i_rst       ( i_rst       ),
    .i_val       ( core_val    ),
    .i_dat_i     ( core_dat    ),
    .o_dat_o     ( o_dat_o     ),
    .o_dat_red_o ( o_dat_red_o ),
    .o_val       ( o_val       )
  );

endmodule

/* logic/multiplier.sv */
// One registered coefficient product of the poly_mod_mult grid, sized for a single DSP
`timescale 1ns/1ns

module multiplier #(
  parameter int IN_BITS = 9
) (
  input  logic                   i_clk,
  input  logic [IN_BITS-1:0]     i_dat_a,
  input  logic [IN_BITS-1:0]     i_dat_b,
  output logic [2*IN_BITS-1:0]   o_dat
);

  logic [2*IN_BITS-1:0] prod;

  // Full width unsigned product
  always_comb begin
    prod = (2*IN_BITS)'(i_dat_a) * (2*IN_BITS)'(i_dat_b);
  end

  // Output register absorbed into the DSP
  always_ff @(posedge i_clk) begin
    o_dat <= prod;
  end

endmodule

/* logic/poly_mod_mult.sv */
// Core pipeline of mod_mult_unit: grid multiply, column sums, carry and table fold to redundant form
`timescale 1ns/1ns

module poly_mod_mult
  import mod_mult_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_rst,
  input  logic  i_val,          // One-cycle request pulse
  input  logic  i_reduce_only,  // Fold operand A only
  input  poly_t i_dat_a_i,
  input  poly_t i_dat_b_i,
  output poly_t o_dat_o,
  output logic  o_val
);

  localparam int PROD_BITS    = 2*COEF_BITS;
  localparam int SPLIT_BITS   = MULT_SPLITS*WORD_BITS;  // Product padded to whole slices
  localparam int COL_IN       = MULT_SPLITS*I_WORD;     // One slot per row and slice
  localparam int COL_BITS     = WORD_BITS + $clog2(COL_IN);
  localparam int UP_BITS      = RED_STAGES*RED_BITS;
  localparam int RED_IN       = UPPER_COLS*RED_STAGES + 1; // Table outputs plus lower word
  localparam int RED_SUM_BITS = COEF_BITS + $clog2(RED_IN);
  localparam int ADDR_IDX     = CORE_STAGES - RED_ONLY_STAGES; // Valid bit of address stage

  logic [CORE_STAGES-1:0] val_q;  // val_q[k] marks stage k+1
  logic                   red_go;

  poly_t dat_a_q;
  poly_t dat_b_q;

  logic [I_WORD-1:0][I_WORD-1:0][PROD_BITS-1:0] mul_out;

  logic [ACCUM_COLS-1:0][COL_BITS-1:0]  col_sum;
  logic [ACCUM_COLS-1:0][WORD_BITS-1:0] col_hi;   // Carry into each column
  coef_t [ACCUM_COLS-1:0]               col_coef;

  logic [UPPER_COLS-1:0][RED_STAGES-1:0][RED_BITS-1:0] up_d;
  logic [UPPER_COLS-1:0][RED_STAGES-1:0][RED_BITS-1:0] lut_addr_q;
  residue_t [UPPER_COLS-1:0][RED_STAGES-1:0]           lut_dat;
  coef_t [NUM_WORDS-1:0]                               low_d;
  coef_t [NUM_WORDS-1:0]                               low_q;

  logic [NUM_WORDS-1:0][RED_SUM_BITS-1:0] red_sum;
  logic [I_WORD-1:0][WORD_BITS-1:0]       red_lo;
  logic [I_WORD-1:0][WORD_BITS-1:0]       red_hi;

  assign red_go = i_val & i_reduce_only;

  // Valid shift register, reduce-only joins at the address stage
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= '0;
    end else begin
      val_q           <= {val_q[CORE_STAGES-2:0], i_val & ~i_reduce_only};
      val_q[ADDR_IDX] <= val_q[ADDR_IDX-1] | red_go; // Slot is never shared
    end
  end

  assign o_val = val_q[CORE_STAGES-1];

  // Stage 1 operand registers
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      dat_a_q <= '0;
      dat_b_q <= '0;
    end else begin
      dat_a_q <= i_dat_a_i;
      dat_b_q <= i_dat_b_i;
    end
  end

  // Stage 2 product grid
  for (genvar gi = 0; gi < I_WORD; gi++) begin : g_mul_row
    for (genvar gj = 0; gj < I_WORD; gj++) begin : g_mul_col
      multiplier #(
        .IN_BITS ( COEF_BITS )
      ) mul (
        .i_clk   ( i_clk             ),
        .i_dat_a ( dat_a_q[gi]       ),
        .i_dat_b ( dat_b_q[gj]       ),
        .o_dat   ( mul_out[gi][gj]   )
      );
    end
  end

  // Stage 3 column sums, slice s of product (i,j) lands in column i+j+s
  for (genvar gk = 0; gk < ACCUM_COLS; gk++) begin : g_col
    logic [COL_IN-1:0][WORD_BITS-1:0] col_in;

    always_comb begin
      int                    j;
      logic [SPLIT_BITS-1:0] prod_ext;
      j        = 0;
      prod_ext = '0;
      col_in   = '0;
      for (int i = 0; i < I_WORD; i++) begin
        for (int s = 0; s < MULT_SPLITS; s++) begin
          j = gk - s - i;
          if (j >= 0 && j < I_WORD) begin
            prod_ext                = SPLIT_BITS'(mul_out[i][j]);
            col_in[i*MULT_SPLITS+s] = prod_ext[s*WORD_BITS +: WORD_BITS];
          end
        end
      end
    end

    tree_adder #(
      .NUM_IN  ( COL_IN    ),
      .IN_BITS ( WORD_BITS )
    ) col_add (
      .i_clk ( i_clk       ),
      .i_dat ( col_in      ),
      .o_dat ( col_sum[gk] )
    );
  end

  // Overflow of each column moves up one; the top column never overflows
  always_comb begin
    col_hi[0] = '0;
    for (int k = 1; k < ACCUM_COLS; k++) begin
      col_hi[k] = WORD_BITS'(col_sum[k-1][COL_BITS-1:WORD_BITS]);
    end
  end

  // Stage 4 one level of carry
  for (genvar gk = 0; gk < ACCUM_COLS; gk++) begin : g_carry
    tree_adder #(
      .NUM_IN  ( 2         ),
      .IN_BITS ( WORD_BITS )
    ) carry_add (
      .i_clk ( i_clk                                    ),
      .i_dat ( {col_hi[gk], col_sum[gk][WORD_BITS-1:0]} ),
      .o_dat ( col_coef[gk]                             )
    );
  end

  // Address source, reduce-only takes operand A in place of the carry stage
  always_comb begin
    for (int u = 0; u < UPPER_COLS; u++) begin
      up_d[u] = '0;
      if (!red_go) begin
        up_d[u] = UP_BITS'(col_coef[u+NUM_WORDS]);
      end else if (u + NUM_WORDS < I_WORD) begin
        up_d[u] = UP_BITS'(i_dat_a_i[u+NUM_WORDS]); // Only the top word of A is upper
      end
    end
    for (int w = 0; w < NUM_WORDS; w++) begin
      low_d[w] = red_go ? i_dat_a_i[w] : col_coef[w];
    end
  end

  // Stage 5 lookup addresses and lower words
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      lut_addr_q <= '0;
      low_q      <= '0;
    end else begin
      lut_addr_q <= up_d;
      low_q      <= low_d;
    end
  end

  for (genvar gu = 0; gu < UPPER_COLS; gu++) begin : g_lut_col
    for (genvar gs = 0; gs < RED_STAGES; gs++) begin : g_lut_slice
      reduction_lut #(
        .BIT_POS ( (gu+NUM_WORDS)*WORD_BITS + gs*RED_BITS )
      ) lut (
        .addr_i ( lut_addr_q[gu][gs] ),
        .data_o ( lut_dat[gu][gs]    )
      );
    end
  end

  // Stage 6 per word sum of table bytes and the kept lower word
  for (genvar gw = 0; gw < NUM_WORDS; gw++) begin : g_red
    logic [RED_IN-1:0][COEF_BITS-1:0] red_in;

    always_comb begin
      for (int u = 0; u < UPPER_COLS; u++) begin
        for (int s = 0; s < RED_STAGES; s++) begin
          red_in[u*RED_STAGES+s] = COEF_BITS'(lut_dat[u][s][gw*WORD_BITS +: WORD_BITS]);
        end
      end
      red_in[RED_IN-1] = low_q[gw];
    end

    tree_adder #(
      .NUM_IN  ( RED_IN    ),
      .IN_BITS ( COEF_BITS )
    ) red_add (
      .i_clk ( i_clk       ),
      .i_dat ( red_in      ),
      .o_dat ( red_sum[gw] )
    );
  end

  // Split sums for the last carry, top word gets only the overflow
  always_comb begin
    red_lo[NUM_WORDS] = '0;
    red_hi[0]         = '0;
    for (int w = 0; w < NUM_WORDS; w++) begin
      red_lo[w]   = red_sum[w][WORD_BITS-1:0];
      red_hi[w+1] = WORD_BITS'(red_sum[w][RED_SUM_BITS-1:WORD_BITS]);
    end
  end

  // Stage 7 final carry into the redundant result
  for (genvar gw = 0; gw < I_WORD; gw++) begin : g_final
    tree_adder #(
      .NUM_IN  ( 2         ),
      .IN_BITS ( WORD_BITS )
    ) final_add (
      .i_clk ( i_clk                    ),
      .i_dat ( {red_hi[gw], red_lo[gw]} ),
      .o_dat ( o_dat_o[gw]              )
    );
  end

endmodule

/* logic/reduction_lut.sv */
// Residue table for one upper-column slice at weight 2^BIT_POS, read combinationally by poly_mod_mult
`timescale 1ns/1ns

module reduction_lut
  import mod_mult_pkg::*;
#(
  parameter int BIT_POS = 32
) (
  input  logic [RED_BITS-1:0] addr_i,
  output residue_t            data_o
);

  localparam int DEPTH = 1 << RED_BITS;

  typedef residue_t [DEPTH-1:0] table_t;

  // Entry a holds (a * 2^BIT_POS) mod MODULUS
  function automatic table_t build_table();
    table_t      tbl;
    logic [63:0] pw;   // 2^BIT_POS mod MODULUS
    logic [63:0] prod;
    pw = 64'd1;
    for (int b = 0; b < BIT_POS; b++) begin
      pw = (pw << 1) % MODULUS; // Doubling keeps pw below 2^33
    end
    for (int a = 0; a < DEPTH; a++) begin
      prod   = 64'(a) * pw;     // Fits, a is 9 bits and pw 32
      tbl[a] = residue_t'(prod % MODULUS);
    end
    return tbl;
  endfunction

  localparam table_t TABLE = build_table();

  assign data_o = TABLE[addr_i];

endmodule

/* logic/redundant_to_binary.sv */
// Converts a redundant poly_t result to a binary residue below the modulus in two stages
`timescale 1ns/1ns

module redundant_to_binary
  import mod_mult_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     i_val,
  input  poly_t    i_dat_i,
  output residue_t o_dat_o,
  output poly_t    o_dat_red_o,  // Redundant copy for chaining
  output logic     o_val
);

  // Weighted coefficient sum is below 2^BIN_BITS
  localparam int BIN_BITS = (I_WORD-1)*WORD_BITS + COEF_BITS + 1;
  localparam int SHIFTS   = BIN_BITS - RES_BITS; // Highest modulus shift that fits

  logic [BIN_BITS-1:0] bin_d;
  logic [BIN_BITS-1:0] bin_q;
  logic [BIN_BITS-1:0] res_d;
  poly_t               red_q;
  logic                val_q;

  // Compare and subtract from the top shift down, leaves r below MODULUS
  function automatic logic [BIN_BITS-1:0] reduce_mod(input logic [BIN_BITS-1:0] x);
    logic [BIN_BITS-1:0] r;
    logic [BIN_BITS-1:0] m;
    r = x;
    for (int sh = SHIFTS; sh >= 0; sh--) begin
      m = BIN_BITS'(MODULUS) << sh;
      if (r >= m) begin
        r = r - m;
      end
    end
    return r;
  endfunction

  // Carry resolution by plain weighted add
  always_comb begin
    bin_d = '0;
    for (int i = 0; i < I_WORD; i++) begin
      bin_d = bin_d + (BIN_BITS'(i_dat_i[i]) << (i*WORD_BITS));
    end
  end

  assign res_d = reduce_mod(bin_q);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q       <= 1'b0;
      o_val       <= 1'b0;
      bin_q       <= '0;
      red_q       <= '0;
      o_dat_o     <= '0;
      o_dat_red_o <= '0;
    end else begin
      val_q       <= i_val;
      o_val       <= val_q;
      bin_q       <= bin_d;        // Stage 1
      red_q       <= i_dat_i;
      o_dat_o     <= residue_t'(res_d); // Stage 2, upper bits are zero
      o_dat_red_o <= red_q;
    end
  end

endmodule

/* logic/tree_adder.sv */
// Balanced adder tree over NUM_IN inputs with one output register, used for all column sums
`timescale 1ns/1ns

module tree_adder #(
  parameter int NUM_IN  = 2,
  parameter int IN_BITS = 8
) (
  input  logic                              i_clk,
  input  logic [NUM_IN-1:0][IN_BITS-1:0]    i_dat,
  output logic [IN_BITS+$clog2(NUM_IN)-1:0] o_dat
);

  localparam int LEVELS   = $clog2(NUM_IN);
  localparam int LEAVES   = 1 << LEVELS;     // Inputs padded up to a power of two
  localparam int OUT_BITS = IN_BITS + LEVELS;

  // Level 0 holds the leaves, level LEVELS the root
  logic [LEVELS:0][LEAVES-1:0][OUT_BITS-1:0] node;

  always_comb begin
    node = '0; // Padding leaves stay zero
    for (int i = 0; i < NUM_IN; i++) begin
      node[0][i] = OUT_BITS'(i_dat[i]);
    end
    // Pairwise sums, half as many nodes per level
    for (int l = 0; l < LEVELS; l++) begin
      for (int i = 0; i < (LEAVES >> (l + 1)); i++) begin
        node[l+1][i] = node[l][2*i] + node[l][2*i+1];
      end
    end
  end

  // Root is registered once
  always_ff @(posedge i_clk) begin
    o_dat <= node[LEVELS][0];
  end

endmodule

/* mod_mult_unit.f */
+incdir+include
logic/mod_mult_pkg.sv
logic/multiplier.sv
logic/tree_adder.sv
logic/reduction_lut.sv
logic/poly_mod_mult.sv
logic/redundant_to_binary.sv
logic/mod_mult_unit.sv
verification/mod_mult_checker.sv
verification/mod_mult_sva.sv
verification/mod_mult_unit_tb.sv

/* verification/mod_mult_checker.sv */
// Scoreboard for mod_mult_unit, models each request from the value rule and checks it at its due cycle
`timescale 1ns/1ns

module mod_mult_checker
  import mod_mult_pkg::*;
(
  input  logic     i_clk,
  input  logic     i_rst,
  input  logic     val_i,        // DUT request side
  input  logic     red_only_i,
  input  poly_t    dat_a_i,
  input  poly_t    dat_b_i,
  input  logic     tab_chk_i,    // Row carries its own expected residue
  input  residue_t tab_res_i,
  input  logic     out_val_i,    // DUT result side
  input  residue_t dat_i,
  input  poly_t    dat_red_i,
  output int       err_cnt_o,
  output int       proto_cnt_o,
  output int       pend_cnt_o
);

  localparam int MUL_DELAY = 9;
  localparam int RED_DELAY = 5;
  localparam int SLOTS     = 16; // Longer than either latency

  residue_t exp_mem [SLOTS]; // Indexed by due cycle
  residue_t tab_mem [SLOTS];
  logic     exp_vld [SLOTS];
  logic     tab_vld [SLOTS];
  int       cyc;

  // Sum of coefficients at weight 2^(8*i), brought below the modulus
  function automatic residue_t value_mod(input poly_t p);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < I_WORD; i++) begin
      v = v + (64'(p[i]) << (i*WORD_BITS)); // Below 2^42, no overflow
    end
    return residue_t'(v % 64'(MODULUS));
  endfunction

  always @(posedge i_clk) begin : score
    int          due;
    residue_t    exp_r;
    logic [63:0] prod;
    if (i_rst) begin
      for (int s = 0; s < SLOTS; s++) begin
        exp_vld[s] = 1'b0;
        tab_vld[s] = 1'b0;
      end
      cyc         = 0;
      err_cnt_o   = 0;
      proto_cnt_o = 0;
      pend_cnt_o  = 0;
    end else begin
      due = cyc % SLOTS;
      if (exp_vld[due] && !out_val_i) begin
        $display("At %0t ns a result due in this cycle did not arrive", $time);
        proto_cnt_o++;
      end else if (!exp_vld[due] && out_val_i) begin
        $display("At %0t ns o_val was high with no request due in this cycle", $time);
        proto_cnt_o++;
      end else if (out_val_i) begin
        if (dat_i !== exp_mem[due]) begin
          $display("error at %0t ns: o_dat_o expected %h, got %h", $time, exp_mem[due], dat_i);
          err_cnt_o++;
        end
        if (tab_vld[due] && dat_i !== tab_mem[due]) begin
          $display("error at %0t ns: o_dat_o expected %h from table, got %h",
                   $time, tab_mem[due], dat_i);
          err_cnt_o++;
        end
        // Redundant copy only has to be congruent
        if (value_mod(dat_red_i) !== exp_mem[due]) begin
          $display("error at %0t ns: o_dat_red_o value mod M expected %h, got %h",
                   $time, exp_mem[due], value_mod(dat_red_i));
          err_cnt_o++;
        end
      end
      if (exp_vld[due]) begin
        exp_vld[due] = 1'b0;
        tab_vld[due] = 1'b0;
        pend_cnt_o--;
      end
      if (val_i) begin
        due = (cyc + (red_only_i ? RED_DELAY : MUL_DELAY)) % SLOTS;
        if (red_only_i) begin
          exp_r = value_mod(dat_a_i); // B is ignored
        end else begin
          prod  = 64'(value_mod(dat_a_i)) * 64'(value_mod(dat_b_i));
          exp_r = residue_t'(prod % 64'(MODULUS));
        end
        if (exp_vld[due]) begin
          $display("At %0t ns two requests fall due in the same cycle", $time);
          proto_cnt_o++;
        end else begin
          pend_cnt_o++;
        end
        exp_mem[due] = exp_r;
        exp_vld[due] = 1'b1;
        tab_mem[due] = tab_res_i;
        tab_vld[due] = tab_chk_i;
      end
      cyc++;
    end
  end

endmodule

/* verification/mod_mult_sva.sv */
// Valid timing assertions that the bind below attaches to every mod_mult_unit instance
`timescale 1ns/1ns

module mod_mult_sva (
  input logic i_clk,
  input logic i_rst,
  input logic i_val,
  input logic i_reduce_only,
  input logic o_val
);

  localparam int MUL_DELAY = 9;
  localparam int RED_DELAY = 5;
  localparam int ADDR_GAP  = 4; // Multiply reaches the address registers here

  logic mul_req;
  logic red_req;
  int   rst_fail;    // Failures per assertion
  int   origin_fail;
  int   slot_fail;

  assign mul_req = i_val & ~i_reduce_only;
  assign red_req = i_val & i_reduce_only;

  // Output register was cleared on the previous reset edge
  a_rst_quiet : assert property (@(posedge i_clk) i_rst && $past(i_rst) |-> !o_val)
    else begin
      $error("o_val high while in reset");
      rst_fail++;
    end

  a_val_origin : assert property (@(posedge i_clk) disable iff (i_rst)
    o_val |-> $past(mul_req, MUL_DELAY) || $past(red_req, RED_DELAY))
    else begin
      $error("o_val without a multiply 9 cycles or reduce-only 5 cycles before");
      origin_fail++;
    end

  // Both would load the lookup address registers at once
  a_addr_slot : assert property (@(posedge i_clk) disable iff (i_rst)
    red_req |-> !$past(mul_req, ADDR_GAP))
    else begin
      $error("reduce-only request 4 cycles after a multiply request");
      slot_fail++;
    end

endmodule

bind mod_mult_unit mod_mult_sva sva_i (
  .i_clk         ( i_clk         ),
  .i_rst         ( i_rst         ),
  .i_val         ( i_val         ),
  .i_reduce_only ( i_reduce_only ),
  .o_val         ( o_val         )
);

/* verification/mod_mult_unit_tb.sv */
// Testbench top for mod_mult_unit that runs a directed table, chained squaring and random rows
`timescale 1ns/1ns

module mod_mult_unit_tb
  import mod_mult_pkg::*;
();

  localparam int       RST_CYCLES = 16;
  localparam int       NUM_TAB    = 22;
  localparam int       NUM_CHAIN  = 8;
  localparam int       NUM_RAND   = 200;
  localparam int       CYC_LIMIT  = (NUM_TAB + NUM_CHAIN + NUM_RAND)*12 + RST_CYCLES + 50;
  localparam residue_t M          = MODULUS;

  typedef struct packed {
    logic       red;  // Reduce-only
    poly_t      a;
    poly_t      b;
    logic       chk;  // res column holds a hand value
    residue_t   res;
    logic [1:0] gap;  // Idle cycles after the row
  } row_t;

  logic     i_clk;
  logic     i_rst;
  logic     i_val;
  logic     i_reduce_only;
  poly_t    i_dat_a_i;
  poly_t    i_dat_b_i;
  logic     o_val;
  residue_t o_dat_o;
  poly_t    o_dat_red_o;
  logic     tab_chk;
  residue_t tab_res;
  int       err_cnt;
  int       proto_cnt;
  int       pend_cnt;
  int       cyc;
  row_t     tab [NUM_TAB];
  logic [3:0]  mul_hist; // Bit k set if a multiply went out k+1 cycles ago
  logic [31:0] rng;

  mod_mult_unit dut_i (
    .i_clk, .i_rst, .i_val, .i_reduce_only, .i_dat_a_i, .i_dat_b_i,
    .o_val, .o_dat_o, .o_dat_red_o
  );

  mod_mult_checker chk (
    .i_clk, .i_rst,
    .val_i       ( i_val         ),
    .red_only_i  ( i_reduce_only ),
    .dat_a_i     ( i_dat_a_i     ),
    .dat_b_i     ( i_dat_b_i     ),
    .tab_chk_i   ( tab_chk       ),
    .tab_res_i   ( tab_res       ),
    .out_val_i   ( o_val         ),
    .dat_i       ( o_dat_o       ),
    .dat_red_i   ( o_dat_red_o   ),
    .err_cnt_o   ( err_cnt       ),
    .proto_cnt_o ( proto_cnt     ),
    .pend_cnt_o  ( pend_cnt      )
  );

  always #50 i_clk = ~i_clk;

  // Run limit
  always @(posedge i_clk) begin
    cyc = cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("Timeout, run still busy after %0d cycles", cyc);
      $display("Test failed");
      $finish;
    end
  end

  // Plain words go in the low coefficients and the top one stays zero
  function automatic poly_t to_poly(input residue_t v);
    poly_t p;
    p = '0;
    for (int i = 0; i < NUM_WORDS; i++) begin
      p[i] = coef_t'(v[i*WORD_BITS +: WORD_BITS]);
    end
    return p;
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic row_t make_row(input logic red, input poly_t a, input poly_t b,
                                    input logic chk, input residue_t res, input int gap);
    row_t r;
    r.red = red;
    r.a   = a;
    r.b   = b;
    r.chk = chk;
    r.res = res;
    r.gap = 2'(gap);
    return r;
  endfunction

  task automatic drive_cycle(input logic v, input row_t r);
    @(negedge i_clk);
    i_val         = v;
    i_reduce_only = r.red;
    i_dat_a_i     = r.a;
    i_dat_b_i     = r.b;
    tab_chk       = r.chk;
    tab_res       = r.res;
    mul_hist      = {mul_hist[2:0], v & ~r.red};
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0);
  endtask

  task automatic send_row(input row_t r);
    while (r.red && mul_hist[3]) begin
      idle_cycle(); // Slot belongs to the multiply leaving the carry stage
    end
    drive_cycle(1'b1, r);
    for (int g = 0; g < r.gap; g++) begin
      idle_cycle();
    end
  endtask

  task automatic wait_drain();
    idle_cycle();
    while (pend_cnt != 0) begin
      idle_cycle();
    end
  endtask

  task automatic fill_table();
    tab[0]  = make_row(0, to_poly(0), to_poly(0), 1, 0, 1);
    tab[1]  = make_row(0, to_poly(1), to_poly(1), 1, 1, 1);
    tab[2]  = make_row(0, to_poly(M-1), to_poly(M-1), 1, 1, 1);
    tab[3]  = make_row(0, to_poly(M-2), to_poly(M-3), 1, 6, 1);
    tab[4]  = make_row(0, to_poly(M-1), to_poly(2), 1, M-2, 1);
    // 2^32+256 is 261 mod M and B is 300 in word 1
    tab[5]  = make_row(0, poly_t'({9'd1, 27'd0, 9'd256}), poly_t'({27'd0, 9'd300, 9'd0}),
                       1, 20044800, 1);
    tab[6]  = make_row(0, poly_t'({I_WORD{9'h1FF}}), to_poly(2), 1, 33691144, 1);
    tab[7]  = make_row(1, to_poly(0), '0, 1, 0, 1);
    tab[8]  = make_row(1, to_poly(M), '0, 1, 0, 1);
    tab[9]  = make_row(1, poly_t'({I_WORD{9'h1FF}}), '0, 1, 16845572, 1);
    tab[10] = make_row(1, to_poly(M-1), '0, 1, M-1, 0); // Back-to-back from here
    tab[11] = make_row(1, poly_t'({9'd1, 36'd0}), '0, 1, 5, 0);
    tab[12] = make_row(1, to_poly(123456789), '0, 1, 123456789, 0);
    for (int k = 0; k < 9; k++) begin
      tab[13+k] = make_row(0, to_poly(k+2), to_poly(M-1), 1, M-(k+2), (k == 8) ? 2 : 0);
    end
  endtask

  initial begin
    poly_t    ra;
    poly_t    rb;
    poly_t    x;
    residue_t sq;
    int       sva_cnt;
    i_clk         = 1'b0;
    i_rst         = 1'b1;
    i_val         = 1'b0;
    i_reduce_only = 1'b0;
    i_dat_a_i     = '0;
    i_dat_b_i     = '0;
    tab_chk       = 1'b0;
    tab_res       = '0;
    mul_hist      = '0;
    cyc           = 0;
    rng           = 32'd87;
    fill_table();
    repeat (RST_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    for (int n = 0; n < NUM_TAB; n++) begin
      send_row(tab[n]);
    end
    wait_drain();
    // Feed the redundant result back while the model squares the plain residue
    sq = 32'h9E3779B9;
    x  = to_poly(sq);
    for (int n = 0; n < NUM_CHAIN; n++) begin
      sq = residue_t'((64'(sq) * 64'(sq)) % 64'(M));
      send_row(make_row(0, x, x, 1, sq, 0));
      idle_cycle();
      while (!o_val) begin
        idle_cycle();
      end
      x = o_dat_red_o;
    end
    for (int n = 0; n < NUM_RAND; n++) begin
      for (int i = 0; i < I_WORD; i++) begin
        rng   = xorshift(rng);
        ra[i] = coef_t'(rng[8:0]);
        rb[i] = coef_t'(rng[24:16]);
      end
      rng = xorshift(rng);
      send_row(make_row(rng[1:0] == 2'b00, ra, rb, 0, '0, rng[8]));
    end
    repeat (12) idle_cycle(); // Longest latency plus margin
    if (pend_cnt != 0) begin
      $display("Results still outstanding at the end of the run: %0d", pend_cnt);
    end
    sva_cnt = dut_i.sva_i.rst_fail + dut_i.sva_i.origin_fail + dut_i.sva_i.slot_fail;
    $display("Closing count: %0d value, %0d protocol, %0d assertion errors, %0d pending",
             err_cnt, proto_cnt, sva_cnt, pend_cnt);
    if (err_cnt == 0 && proto_cnt == 0 && sva_cnt == 0 && pend_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
